/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP = frontPanelTb
FILELIST = tb.f
OBJDIR = obj_dir
LOG = sim.log
PASSMSG = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides, the simulator exit status is not trusted alone.
run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/clockGen.sv */
module clockGen
#(
	parameter int periodNs = 20,
	parameter int resetCycles = 16
)
(
	output logic c100Hz,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		c100Hz = 1'b0;
		arstN = 1'b0;
		repeat (resetCycles) @(negedge c100Hz);
		arstN = 1'b1; // released on a falling edge, away from the capturing edge.
	end

	always #(periodNs / 2) c100Hz = ~c100Hz;

endmodule

/* dv/frontPanelTb.sv */
module frontPanelTb
	import panelPkg::*;
	import busPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int refreshPeriod = 12;
	localparam int resetCycles = 16;
	localparam probeSel errEntry = 4'd11;

	typedef struct packed
	{
		logic [7:0]  sw;
		logic        half;
		logic        load;
		logic [31:0] data;
		logic [15:0] expDigits;
	} stepRow;

	localparam int rowCount = 8;
	localparam int cycleLimit = rowCount * 8 * refreshPeriod + resetCycles;

	// columns are sw, half button, load, probe data and the expected hex digits.
	localparam stepRow steps [rowCount] = '{
		'{8'h00, 1'b0, 1'b0, 32'hA5C3_1234, 16'h1234},
		'{8'h30, 1'b1, 1'b0, 32'hBEEF_0F0F, 16'hBEEF},
		'{8'h56, 1'b0, 1'b1, 32'h0000_9ABC, 16'h9ABC},
		'{8'hB0, 1'b0, 1'b0, 32'hDEAD_DEAD, 16'h9ABC},
		'{8'hC0, 1'b1, 1'b0, 32'h1357_2468, 16'h1357},
		'{8'h28, 1'b0, 1'b1, 32'h8C4A_F00D, 16'hF00D},
		'{8'hF3, 1'b1, 1'b1, 32'h7E57_C0DE, 16'h7E57},
		'{8'h80, 1'b0, 1'b1, 32'h0246_8ACE, 16'h8ACE}
	};

	// lit segments {g,f,e,d,c,b,a} of each hex digit.
	localparam logic [6:0] digitLit [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	logic        c100Hz;
	logic        arstN;
	logic [7:0]  sw = '0;
	panelButtons btn = '0;
	wbRsp        wbIn = '0;
	wbReq        wbOut;
	segDrive     disp;
	logic [7:0]  led;
	logic [2:0]  clkSel;

	logic [31:0] probe [probeCount];
	logic [31:0] rngState = 32'h48cf;
	logic        slaveBusy;
	logic [1:0]  waitLeft;
	int          cycleCount = 0;
	int          checkCount = 0;
	int          errorCount = 0;
	logic [31:0] modelShown = '0;
	logic        modelBusErr = 1'b0;
	panelCtrl    modelCtrl = '0;

	clockGen #(.periodNs(20), .resetCycles(resetCycles)) u_clockGen
	(
		.c100Hz(c100Hz),
		.arstN(arstN)
	);

	frontPanel #(.refreshPeriod(refreshPeriod), .addrWidth(16)) u_dut
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.sw(sw),
		.btn(btn),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.disp(disp),
		.led(led),
		.clkSel(clkSel)
	);

	bind frontPanel frontPanelAsserts u_asserts
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.wbOut(wbOut),
		.wbIn(wbIn),
		.disp(disp)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic probeSel probeIndex(input logic [15:0] adr);
		logic [31:0] offs;
		offs = 32'(adr) - probeBase;
		return offs[5:2];
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAIL %0t %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// probe slave with 0 to 3 wait cycles on top of its registered answer.
	always @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			wbIn <= '0;
			slaveBusy <= 1'b0;
			waitLeft <= 2'd0;
		end
		else
		begin
			wbIn.ack <= 1'b0;
			wbIn.err <= 1'b0;
			if (wbOut.cyc && wbOut.stb && !wbIn.ack && !wbIn.err)
			begin
				if (!slaveBusy)
				begin
					rngState <= lcgNext(rngState);
					waitLeft <= rngState[31:30];
					slaveBusy <= 1'b1;
				end
				else if (waitLeft != 2'd0)
					waitLeft <= waitLeft - 2'd1;
				else
				begin
					slaveBusy <= 1'b0;
					if (probeIndex(wbOut.adr) == errEntry)
						wbIn.err <= 1'b1;
					else
					begin
						wbIn.ack <= 1'b1;
						wbIn.dat <= probe[probeIndex(wbOut.adr)];
					end
				end
			end
		end
	end

	always @(posedge c100Hz)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Something failed");
			$finish;
		end
	end

	// arm is held before load rises, as an operator would do it.
	task automatic loadControl(input logic [7:0] value, input logic half);
		btn <= '{halfBtn: half, armBtn: 1'b1, loadBtn: 1'b0, stepBtn: 1'b0};
		repeat (2) @(posedge c100Hz);
		btn <= '{halfBtn: half, armBtn: 1'b1, loadBtn: 1'b1, stepBtn: 1'b0};
		repeat (4) @(posedge c100Hz);
		btn <= '{halfBtn: half, armBtn: 1'b0, loadBtn: 1'b0, stepBtn: 1'b0};
		modelCtrl = panelCtrl'(value);
		@(negedge c100Hz);
		checkValue(32'(clkSel), 32'(modelCtrl.clkSel), "clkSel after load");
	endtask

	task automatic checkLeds(input logic half, input probeSel sel);
		logic [7:0] expLed;
		if (modelCtrl.ledStatus)
			expLed = {1'b0, modelBusErr, half, 1'b0, sel};
		else
			expLed = modelShown[7:0];
		checkValue(32'(led), 32'(expLed), "LED byte");
	endtask

	task automatic checkDisplay(input logic [15:0] digits);
		int d;
		logic [3:0] seen;
		logic [7:0] expSeg;
		seen = '0;
		repeat (digitCount)
		begin
			@(negedge c100Hz);
			checkValue(32'($countones(~disp.an)), 32'd1, "anodes driven");
			d = 0;
			for (int i = 0; i < digitCount; i++)
				if (!disp.an[i])
					d = i;
			seen[d] = 1'b1;
			if (modelCtrl.rawSeg)
				expSeg = ~modelShown[d*8 +: 8];
			else
				expSeg = {1'b1, ~digitLit[digits[d*4 +: 4]]};
			checkValue(32'(disp.seg), 32'(expSeg), $sformatf("segments of digit %0d", d));
		end
		checkValue(32'(seen), 32'hF, "digits covered by the scan");
	endtask

	task automatic runStep(input stepRow row);
		probeSel sel;
		sel = row.sw[7:4];
		probe[sel] = row.data;
		@(posedge c100Hz);
		sw <= row.sw;
		btn <= '{halfBtn: row.half, armBtn: 1'b0, loadBtn: 1'b0, stepBtn: 1'b0};
		repeat (3) @(posedge c100Hz);
		if (row.load)
			loadControl(row.sw, row.half);
		@(negedge c100Hz);
		// skip a read that may have latched the old switches.
		while (wbOut.cyc)
			@(negedge c100Hz);
		while (!wbOut.cyc)
			@(negedge c100Hz);
		checkValue(32'(wbOut.adr), probeBase + 32'(sel) * 32'd4, "request address");
		checkValue(32'(wbOut.we), 32'd0, "request we");
		while (wbOut.cyc)
			@(negedge c100Hz);
		if (sel == errEntry)
			modelBusErr = 1'b1;
		else
		begin
			modelShown = row.data;
			modelBusErr = 1'b0;
		end
		checkLeds(row.half, sel);
		@(negedge c100Hz); // disp trails shownValue by a cycle.
		checkDisplay(row.expDigits);
	endtask

	initial
	begin
		for (int i = 0; i < probeCount; i++)
			probe[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0101_0101);
		@(posedge arstN);
		#2;
		checkValue(32'(wbOut.cyc), 32'd0, "cyc after reset");
		checkValue(32'(wbOut.stb), 32'd0, "stb after reset");
		checkValue(32'(clkSel), 32'd0, "clkSel after reset");
		checkValue(32'(disp), 32'hFFF, "display after reset");
		repeat (8)
		begin
			@(negedge c100Hz);
			checkValue(32'(wbOut.cyc), 32'd0, "cyc before first refresh");
		end
		for (int i = 0; i < rowCount; i++)
			runStep(steps[i]);
		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, u_dut.u_asserts.failCount);
		if (errorCount == 0 && u_dut.u_asserts.failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* dv/frontPanel_asserts.sv */
module frontPanelAsserts
	import panelPkg::*;
	import busPkg::*;
(
	input logic    c100Hz,
	input logic    arstN,
	input wbReq    wbOut,
	input wbRsp    wbIn,
	input segDrive disp
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// the master holds its request through every wait cycle.
	holdRequest: assert property (@(posedge c100Hz) disable iff (!arstN)
		wbOut.cyc && !wbIn.ack && !wbIn.err
		|=> wbOut.cyc && wbOut.stb && $stable(wbOut.adr))
		else begin failCount++; $error("request dropped or changed before ack"); end

	dropAfterEnd: assert property (@(posedge c100Hz) disable iff (!arstN)
		wbOut.cyc && (wbIn.ack || wbIn.err) |=> !wbOut.cyc && !wbOut.stb)
		else begin failCount++; $error("cyc or stb still high after ack or err"); end

	// the scan moves on by one digit every cycle and wraps after digit 3.
	scanStep: assert property (@(posedge c100Hz) disable iff (!arstN)
		disp.an != 4'hF |=> disp.an == {$past(disp.an[2:0]), $past(disp.an[3])})
		else begin failCount++; $error("anode scan out of order"); end

endmodule

/* logic/busPkg.sv */
package busPkg;

	// width of the adr field on the port, upper bits beyond addrWidth stay zero.
	localparam int wbAdrBits = 16;

	typedef struct packed
	{
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [wbAdrBits-1:0] adr;
	} wbReq;

	typedef struct packed
	{
		logic        ack;
		logic        err;
		logic [31:0] dat;
	} wbRsp;

	typedef logic [3:0] probeSel;

	localparam logic [31:0] probeBase = 32'h0000_4000;
	localparam int probeCount = 16;

	// byte address of one probe register, registers are 32 bits apart.
	function automatic logic [31:0] probeAddr(input probeSel idx);
		return probeBase + {26'd0, idx, 2'b00};
	endfunction

endpackage

/* logic/frontPanel.sv */
module frontPanel
	import panelPkg::*;
	import busPkg::*;
#(
	parameter int refreshPeriod = 50,
	parameter int addrWidth = 16
)
(
	input  logic        c100Hz,
	input  logic        arstN,
	input  logic [7:0]  sw,
	input  panelButtons btn,
	input  wbRsp        wbIn,
	output wbReq        wbOut,
	output segDrive     disp,
	output logic [7:0]  led,
	output logic [2:0]  clkSel
);

	panelButtons btnLevel;
	panelButtons btnRise;
	logic [7:0]  swLevel;
	logic [1:0]  digitSel;
	logic        refreshTick;
	logic [31:0] shownValue;
	panelCtrl    ctrl;

	inputSync #(.payloadT(panelButtons)) syncBtn
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.din(btn),
		.level(btnLevel),
		.rise(btnRise)
	);

	// switches are only read as levels.
	inputSync #(.payloadT(logic [7:0])) syncSw
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.din(sw),
		.level(swLevel),
		.rise()
	);

	scanTimer #(.refreshPeriod(refreshPeriod)) u_scanTimer
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.digitSel(digitSel),
		.refreshTick(refreshTick)
	);

	panelSequencer #(.addrWidth(addrWidth)) u_panelSequencer
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.refreshTick(refreshTick),
		.btnLevel(btnLevel),
		.btnRise(btnRise),
		.sw(swLevel),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.shownValue(shownValue),
		.ctrl(ctrl),
		.led(led)
	);

	segmentDriver u_segmentDriver
	(
		.c100Hz(c100Hz),
		.arstN(arstN),
		.digitSel(digitSel),
		.shownValue(shownValue),
		.rawSeg(ctrl.rawSeg),
		.halfSel(btnLevel.halfBtn),
		.disp(disp)
	);

	assign clkSel = ctrl.clkSel; // goes to the clock mux outside this block.

endmodule

/* logic/inputSync.sv */
module inputSync
#(
	parameter type payloadT = logic [7:0]
)
(
	input  logic    c100Hz,
	input  logic    arstN,
	input  payloadT din,
	output payloadT level,
	output payloadT rise
);

	payloadT stage1;
	payloadT stage2;
	payloadT prevLevel;

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			stage1 <= '0;
			stage2 <= '0;
			prevLevel <= '0;
		end
		else
		begin
			stage1 <= din; // first stage may go metastable.
			stage2 <= stage1;
			prevLevel <= stage2;
		end
	end

	assign level = stage2;

	// high in the first cycle a bit shows up high at the level output.
	assign rise = payloadT'(stage2 & ~prevLevel);

endmodule

/* logic/panelPkg.sv */
package panelPkg;

	// one bit per push button, stepBtn sits in bit 0.
	typedef struct packed
	{
		logic halfBtn;
		logic armBtn;
		logic loadBtn;
		logic stepBtn;
	} panelButtons;

	// the 8-bit control register as it is loaded from the switches.
	typedef struct packed
	{
		logic [2:0] spare;
		logic       ledStatus; // status byte on the LEDs.
		logic       rawSeg;    // raw segment bytes instead of hex.
		logic [2:0] clkSel;
	} panelCtrl;

	// both halves are active low, dp is the top seg bit.
	typedef struct packed
	{
		logic [3:0] an;
		logic [7:0] seg;
	} segDrive;

	localparam int digitCount = 4;

	// blank display, every anode and segment released.
	localparam segDrive segDriveOff = '{an: 4'hF, seg: 8'hFF};

endpackage

/* logic/panelSequencer.sv */
module panelSequencer
	import panelPkg::*;
	import busPkg::*;
#(
	parameter int addrWidth = 16
)
(
	input  logic        c100Hz,
	input  logic        arstN,
	input  logic        refreshTick,
	input  panelButtons btnLevel,
	input  panelButtons btnRise,
	input  logic [7:0]  sw,
	input  wbRsp        wbIn,
	output wbReq        wbOut,
	output logic [31:0] shownValue,
	output panelCtrl    ctrl,
	output logic [7:0]  led
);

	typedef enum logic [1:0]
	{
		idle,
		request,
		done
	} seqState;

	seqState              state;
	probeSel              srcSel;
	logic [31:0]          fullAdr;
	logic [addrWidth-1:0] adrQ;
	logic                 busErr;

	assign srcSel = probeSel'(sw[7:4]);
	assign fullAdr = probeAddr(srcSel);

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			shownValue <= '0;
			busErr <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (refreshTick)
						state <= request;
				end
				request:
				begin
					if (wbIn.ack)
					begin
						shownValue <= wbIn.dat;
						busErr <= 1'b0; // a good read clears the error.
						state <= done;
					end
					else if (wbIn.err)
					begin
						busErr <= 1'b1;
						state <= done;
					end
				end
				default:
					state <= idle; // done lasts one cycle, ticks in it are dropped.
			endcase
		end
	end

	// the address is taken once per transfer and held until it ends.
	always_ff @(posedge c100Hz)
	begin
		if (state == idle && refreshTick)
			adrQ <= fullAdr[addrWidth-1:0];
	end

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
			ctrl <= '0;
		else if (btnRise.loadBtn && btnLevel.armBtn)
			ctrl <= panelCtrl'(sw);
	end

	always_comb
	begin
		wbOut.cyc = (state == request);
		wbOut.stb = (state == request);
		wbOut.we = 1'b0; // the panel only ever reads.
		wbOut.adr = wbAdrBits'(adrQ);
	end

	always_comb
	begin
		if (ctrl.ledStatus)
			led = {wbOut.cyc, busErr, btnLevel.halfBtn, 1'b0, srcSel};
		else
			led = shownValue[7:0];
	end

endmodule

/* logic/scanTimer.sv */
module scanTimer
#(
	parameter int refreshPeriod = 50
)
(
	input  logic       c100Hz,
	input  logic       arstN,
	output logic [1:0] digitSel,
	output logic       refreshTick
);

	localparam int cntBits = $clog2(refreshPeriod + 1);
	localparam logic [cntBits-1:0] reloadVal = cntBits'(refreshPeriod - 1);

	logic [1:0]         digitCnt;
	logic [cntBits-1:0] refreshCnt;

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			digitCnt <= 2'd0;
			refreshCnt <= reloadVal;
		end
		else
		begin
			digitCnt <= digitCnt + 2'd1; // wraps after digit 3.
			if (refreshCnt == '0)
				refreshCnt <= reloadVal;
			else
				refreshCnt <= refreshCnt - 1'b1;
		end
	end

	assign digitSel = digitCnt;
	assign refreshTick = (refreshCnt == '0);

endmodule

/* logic/segmentDriver.sv */
module segmentDriver
	import panelPkg::*;
(
	input  logic        c100Hz,
	input  logic        arstN,
	input  logic [1:0]  digitSel,
	input  logic [31:0] shownValue,
	input  logic        rawSeg,
	input  logic        halfSel,
	output segDrive     disp
);

	logic [15:0] halfWord;
	logic [3:0]  nibble;
	logic [7:0]  rawByte;
	segDrive     nextDrive;

	// active-low pattern {dp,g,f,e,d,c,b,a} with dp dark.
	function automatic logic [7:0] hexSeg(input logic [3:0] val);
		logic [6:0] lit;
		case (val)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return {1'b1, ~lit};
	endfunction

	assign halfWord = halfSel ? shownValue[31:16] : shownValue[15:0];
	assign nibble = halfWord[digitSel*4 +: 4];
	assign rawByte = shownValue[digitSel*8 +: 8];

	always_comb
	begin
		nextDrive.an = ~(4'b0001 << digitSel); // one anode low per scan step.
		if (rawSeg)
			nextDrive.seg = ~rawByte;
		else
			nextDrive.seg = hexSeg(nibble);
	end

	always_ff @(posedge c100Hz or negedge arstN)
	begin
		if (!arstN)
			disp <= segDriveOff;
		else
			disp <= nextDrive;
	end

endmodule

/* tb.f */
logic/panelPkg.sv
logic/busPkg.sv
logic/inputSync.sv
logic/scanTimer.sv
logic/panelSequencer.sv
logic/segmentDriver.sv
logic/frontPanel.sv
dv/clockGen.sv
dv/frontPanel_asserts.sv
dv/frontPanelTb.sv
